// File: filelist.f
+incdir+hw
hw/spi_frame_pkg.sv
hw/periph_pkg.sv
hw/spi_frame_rx.sv
hw/reg_write_decode.sv
hw/periph_reg_bank.sv
hw/cs_fanout.sv
hw/spi_periph_top.sv
tests/spi_periph_tb.sv

// File: hw/cs_fanout.sv
module cs_fanout
  import periph_pkg::*;
(
  input  logic     cs,
  input  logic     rst_n,
  input  mux_sel_t reg_mux,
  input  logic     ss_n_sync,
  output mux_sel_t periph_cs_n
);

  // selected bits follow the host slave select
  // unselected bits stay high
  mux_sel_t cs_n_d;

  // low only where the mux bit is set and the host select is active
  assign cs_n_d = ~(reg_mux & {$bits(mux_sel_t){~ss_n_sync}});

  // registered so the select lines cannot glitch
  always_ff @(posedge cs or negedge rst_n)
  begin
    if (!rst_n)
      // all peripherals deselected
      periph_cs_n <= '1;
    else
      periph_cs_n <= cs_n_d;
  end

endmodule

// File: hw/periph_pkg.sv
package periph_pkg;

  // one bit per peripheral select
  // set bit routes the host slave select to that peripheral
  typedef logic [7:0] mux_sel_t;

  // LED drive word
  typedef logic [7:0] led_t;

  // DAC control pins
  // [3] LDAC
  // [2] reset
  // [1] uni/bip A
  // [0] uni/bip B
  typedef logic [3:0] dac_ctl_t;

  // bit positions in dac_ctl_t
  localparam int DAC_LDAC_BIT  = 3;
  localparam int DAC_RST_BIT   = 2;
  localparam int DAC_UBIP_A    = 1;
  localparam int DAC_UBIP_B    = 0;

  // sanity on the positions, all within the word
  localparam int DAC_CTL_BITS  = $bits(dac_ctl_t);

endpackage

// File: hw/periph_reg_bank.sv
module periph_reg_bank
  import spi_frame_pkg::*;
  import periph_pkg::*;
(
  input  logic     cs,
  input  logic     rst_n,
  input  logic     wr_mux,
  input  logic     wr_led,
  input  logic     wr_dac,
  input  reg_val_t wr_val,
  output mux_sel_t reg_mux,
  output led_t     led,
  output dac_ctl_t dac_ctl
);

  // register load, one cycle after its strobe
  always_ff @(posedge cs or negedge rst_n)
  begin
    if (!rst_n)
    begin
      reg_mux <= '0;
      led     <= '0;
      dac_ctl <= '0;
    end
    else
    begin
      if (wr_mux)
        reg_mux <= mux_sel_t'(wr_val);
      if (wr_led)
        led <= led_t'(wr_val);
      // only the low nibble means anything to the DAC
      if (wr_dac)
        dac_ctl <= wr_val[DAC_CTL_BITS-1:0];
    end
  end

  // no register moves without its own strobe
  a_mux_only_on_wr : assert property (@(posedge cs) disable iff (!rst_n)
    !$stable(reg_mux) |-> $past(wr_mux));

  a_led_only_on_wr : assert property (@(posedge cs) disable iff (!rst_n)
    !$stable(led) |-> $past(wr_led));

  a_dac_only_on_wr : assert property (@(posedge cs) disable iff (!rst_n)
    !$stable(dac_ctl) |-> $past(wr_dac));

endmodule

// File: hw/reg_write_decode.sv
`include "spi_regs_macros.svh"

module reg_write_decode
  import spi_frame_pkg::*;
(
  input  logic      cs,
  input  logic      rst_n,
  input  logic      frame_valid,
  input  reg_addr_t frame_addr,
  input  reg_val_t  frame_val,
  output logic      wr_mux,
  output logic      wr_led,
  output logic      wr_dac,
  output reg_val_t  wr_val,
  output logic      addr_err
);

  // strobes, one cycle after frame_valid
  always_ff @(posedge cs or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_mux   <= 1'b0;
      wr_led   <= 1'b0;
      wr_dac   <= 1'b0;
      addr_err <= 1'b0;
    end
    else
    begin
      wr_mux   <= 1'b0;
      wr_led   <= 1'b0;
      wr_dac   <= 1'b0;
      addr_err <= 1'b0;
      if (frame_valid)
      begin
        case (frame_addr)
          reg_addr_t'(`SPI_ADDR_MUX): wr_mux <= 1'b1;
          reg_addr_t'(`SPI_ADDR_LED): wr_led <= 1'b1;
          reg_addr_t'(`SPI_ADDR_DAC): wr_dac <= 1'b1;
          // unknown address, nothing written
          default:                    addr_err <= 1'b1;
        endcase
      end
    end
  end

  // value rides alongside the strobe
  always_ff @(posedge cs)
  begin
    if (frame_valid)
      wr_val <= frame_val;
  end

  a_one_strobe : assert property (@(posedge cs) disable iff (!rst_n)
    $onehot0({wr_mux, wr_led, wr_dac}));

endmodule

// File: hw/spi_frame_pkg.sv
package spi_frame_pkg;

  // whole frame as it sits in the shift register
  typedef logic [15:0] frame_t;

  // high byte of a frame
  typedef logic [7:0] reg_addr_t;

  // low byte of a frame
  typedef logic [7:0] reg_val_t;

  // bits seen in a frame, must reach 17 to catch overlong frames
  typedef logic [4:0] bit_cnt_t;

  // receiver state
  typedef enum logic [1:0] {
    // slave select high, waiting
    RX_IDLE  = 2'd0,
    // slave select low, special low, taking bits
    RX_SHIFT = 2'd1,
    // special seen during this frame, drop it
    RX_SKIP  = 2'd2
  } rx_state_t;

endpackage

// File: hw/spi_frame_rx.sv
`include "spi_regs_macros.svh"

module spi_frame_rx
  import spi_frame_pkg::*;
(
  input  logic      cs,
  input  logic      rst_n,
  input  logic      spi_sclk,
  input  logic      spi_ss_n,
  input  logic      spi_mosi,
  input  logic      spi_special,
  output logic      frame_valid,
  output logic      frame_err,
  output reg_addr_t frame_addr,
  output reg_val_t  frame_val,
  output logic      ss_n_sync
);

  // synchronizer chains, pin enters at bit 0
  logic [`SPI_SYNC_STAGES-1:0] sclk_sq;
  logic [`SPI_SYNC_STAGES-1:0] ss_sq;
  logic [`SPI_SYNC_STAGES-1:0] mosi_sq;
  logic [`SPI_SYNC_STAGES-1:0] special_sq;

  // previous synchronized levels for edge detect
  logic      sclk_d;
  logic      ss_d;
  logic      sclk_s;
  logic      mosi_s;
  logic      special_s;
  logic      sclk_fall;
  logic      ss_fall;
  logic      ss_rise;

  frame_t    shift_q;
  bit_cnt_t  cnt_q;
  rx_state_t state_q;
  rx_state_t state_d;

  always_ff @(posedge cs or negedge rst_n)
  begin
    if (!rst_n)
    begin
      // slave select idles high
      sclk_sq    <= '0;
      ss_sq      <= '1;
      mosi_sq    <= '0;
      special_sq <= '0;
      sclk_d     <= 1'b0;
      ss_d       <= 1'b1;
    end
    else
    begin
      sclk_sq    <= {sclk_sq[`SPI_SYNC_STAGES-2:0], spi_sclk};
      ss_sq      <= {ss_sq[`SPI_SYNC_STAGES-2:0], spi_ss_n};
      mosi_sq    <= {mosi_sq[`SPI_SYNC_STAGES-2:0], spi_mosi};
      special_sq <= {special_sq[`SPI_SYNC_STAGES-2:0], spi_special};
      sclk_d     <= sclk_s;
      ss_d       <= ss_n_sync;
    end
  end

  assign sclk_s    = sclk_sq[`SPI_SYNC_STAGES-1];
  assign ss_n_sync = ss_sq[`SPI_SYNC_STAGES-1];
  assign mosi_s    = mosi_sq[`SPI_SYNC_STAGES-1];
  assign special_s = special_sq[`SPI_SYNC_STAGES-1];

  // data sampled on sclk falling edge
  assign sclk_fall = sclk_d & ~sclk_s;
  assign ss_fall   = ss_d & ~ss_n_sync;
  assign ss_rise   = ~ss_d & ss_n_sync;

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      RX_IDLE:
      begin
        if (ss_fall)
          state_d = special_s ? RX_SKIP : RX_SHIFT;
      end
      RX_SHIFT:
      begin
        // end of frame wins over a late special
        if (ss_rise)
          state_d = RX_IDLE;
        else if (special_s)
          state_d = RX_SKIP;
      end
      RX_SKIP:
      begin
        if (ss_rise)
          state_d = RX_IDLE;
      end
      default:
        state_d = RX_IDLE;
    endcase
  end

  always_ff @(posedge cs or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q     <= RX_IDLE;
      cnt_q       <= '0;
      frame_valid <= 1'b0;
      frame_err   <= 1'b0;
    end
    else
    begin
      state_q     <= state_d;
      // one pulse per closed frame, count decides which
      frame_valid <= (state_q == RX_SHIFT) && ss_rise && !special_s &&
                     (cnt_q == bit_cnt_t'(`SPI_FRAME_BITS));
      frame_err   <= (state_q == RX_SHIFT) && ss_rise && !special_s &&
                     (cnt_q != bit_cnt_t'(`SPI_FRAME_BITS));
      if (state_q == RX_IDLE && ss_fall)
        cnt_q <= '0;
      else if (state_q == RX_SHIFT && sclk_fall &&
               cnt_q != bit_cnt_t'(`SPI_FRAME_BITS + 1))
        // saturate one past a full frame
        cnt_q <= cnt_q + 1'b1;
    end
  end

  // shift word, only moves inside a live frame
  always_ff @(posedge cs)
  begin
    if (state_q == RX_SHIFT && sclk_fall)
      shift_q <= {shift_q[`SPI_FRAME_BITS-2:0], mosi_s};
  end

  // held stable while idle, so valid on the pulse
  assign frame_addr = shift_q[`SPI_FRAME_BITS-1 -: `SPI_ADDR_BITS];
  assign frame_val  = shift_q[`SPI_VAL_BITS-1:0];

  // a closed frame is either good or bad
  a_valid_err_excl : assert property (@(posedge cs) disable iff (!rst_n)
    !(frame_valid && frame_err));

endmodule

// File: hw/spi_periph_top.sv
module spi_periph_top
  import spi_frame_pkg::*;
  import periph_pkg::*;
(
  input  logic     cs,
  input  logic     rst_n,
  input  logic     spi_sclk,
  input  logic     spi_ss_n,
  input  logic     spi_mosi,
  input  logic     spi_special,
  output led_t     led,
  output dac_ctl_t dac_ctl,
  output mux_sel_t periph_cs_n,
  output logic     frame_err,
  output logic     addr_err
);

  // receiver to decoder
  logic      frame_valid;
  reg_addr_t frame_addr;
  reg_val_t  frame_val;
  logic      ss_n_sync;

  // decoder to register bank
  logic      wr_mux;
  logic      wr_led;
  logic      wr_dac;
  reg_val_t  wr_val;

  // register bank to fanout
  mux_sel_t  reg_mux;

  spi_frame_rx u_rx (
    .cs          (cs),
    .rst_n       (rst_n),
    .spi_sclk    (spi_sclk),
    .spi_ss_n    (spi_ss_n),
    .spi_mosi    (spi_mosi),
    .spi_special (spi_special),
    .frame_valid (frame_valid),
    .frame_err   (frame_err),
    .frame_addr  (frame_addr),
    .frame_val   (frame_val),
    .ss_n_sync   (ss_n_sync)
  );

  reg_write_decode u_dec (
    .cs          (cs),
    .rst_n       (rst_n),
    .frame_valid (frame_valid),
    .frame_addr  (frame_addr),
    .frame_val   (frame_val),
    .wr_mux      (wr_mux),
    .wr_led      (wr_led),
    .wr_dac      (wr_dac),
    .wr_val      (wr_val),
    .addr_err    (addr_err)
  );

  periph_reg_bank u_regs (
    .cs      (cs),
    .rst_n   (rst_n),
    .wr_mux  (wr_mux),
    .wr_led  (wr_led),
    .wr_dac  (wr_dac),
    .wr_val  (wr_val),
    .reg_mux (reg_mux),
    .led     (led),
    .dac_ctl (dac_ctl)
  );

  // transparent SPI routing to the board peripherals
  cs_fanout u_fanout (
    .cs          (cs),
    .rst_n       (rst_n),
    .reg_mux     (reg_mux),
    .ss_n_sync   (ss_n_sync),
    .periph_cs_n (periph_cs_n)
  );

endmodule

// File: hw/spi_regs_macros.svh
`ifndef SPI_REGS_MACROS_SVH
`define SPI_REGS_MACROS_SVH

// frame layout, msb first
// high byte is the register address, low byte the value
`define SPI_FRAME_BITS 16

// field widths inside a frame
`define SPI_ADDR_BITS 8
`define SPI_VAL_BITS 8

// register addresses as seen by the host MCU
// chip-select mux
`define SPI_ADDR_MUX 8

// board LEDs
`define SPI_ADDR_LED 7

// DAC control pins (LDAC, reset, uni/bip A, uni/bip B)
`define SPI_ADDR_DAC 9

// flops per synchronizer chain on the SPI pins
// host holds each sclk level at least 3 cs cycles
`define SPI_SYNC_STAGES 2

`endif

// File: run_sim.sh
#!/bin/sh
# build and run the SPI peripheral testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --assert -Wno-fatal -f filelist.f \
  --top-module spi_periph_tb -o spi_periph_sim > build.log 2>&1 \
  || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/spi_periph_sim > sim.log 2>&1
cat sim.log
grep -q "Simulation PASSED" sim.log && echo "run passed" || { echo "run failed"; exit 1; }

// File: tests/spi_periph_tb.sv
`include "spi_regs_macros.svh"

module spi_periph_tb
  import spi_frame_pkg::*;
  import periph_pkg::*;
();

  // cs cycles per sclk level
  localparam int SCLK_HALF = 4;
  // run length budget of 60 frames at about 150 cycles each
  // doubled with 2000 cycles of margin
  localparam int MAX_FRAMES = 60;
  localparam int FRAME_CYCLES = 150;
  localparam int TIMEOUT_CYCLES = 2 * MAX_FRAMES * FRAME_CYCLES + 2000;

  logic     cs;
  logic     rst_n;
  logic     spi_sclk;
  logic     spi_ss_n;
  logic     spi_mosi;
  logic     spi_special;
  led_t     led;
  dac_ctl_t dac_ctl;
  mux_sel_t periph_cs_n;
  logic     frame_err;
  logic     addr_err;

  integer   seed = 32'h84ac_f8eb;

  // shadow of the register bank and expected pulse totals
  mux_sel_t exp_mux = '0;
  led_t     exp_led = '0;
  dac_ctl_t exp_dac = '0;
  int       exp_frame_errs = 0;
  int       exp_addr_errs = 0;

  // pulses seen on the DUT outputs
  int       frame_err_seen = 0;
  int       addr_err_seen = 0;

  int       cycle_cnt = 0;
  // cycle numbers of the next mid frame and end of frame compares
  int       mid_check_at = -1;
  int       end_check_at = -1;
  int       fail_cnt = 0;

  spi_periph_top dut0 (
    .cs          (cs),
    .rst_n       (rst_n),
    .spi_sclk    (spi_sclk),
    .spi_ss_n    (spi_ss_n),
    .spi_mosi    (spi_mosi),
    .spi_special (spi_special),
    .led         (led),
    .dac_ctl     (dac_ctl),
    .periph_cs_n (periph_cs_n),
    .frame_err   (frame_err),
    .addr_err    (addr_err)
  );

  initial
  begin
    cs = 1'b0;
    forever #20 cs = ~cs;
  end

  task automatic stop_with_failure();
    $display("Simulation FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  // cycle count and hang guard
  always @(posedge cs)
  begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES)
    begin
      $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      stop_with_failure();
    end
  end

  // count error pulses between clock edges
  always @(negedge cs)
  begin
    if (rst_n && frame_err)
      frame_err_seen = frame_err_seen + 1;
    if (rst_n && addr_err)
      addr_err_seen = addr_err_seen + 1;
  end

  task automatic check_led(input string name, input led_t exp, input led_t act);
    if (exp !== act)
    begin
      fail_cnt = fail_cnt + 1;
      $display("[FAIL] t=%0t %s expected %h got %h", $time, name, exp, act);
      stop_with_failure();
    end
  endtask

  task automatic check_dac(input string name, input dac_ctl_t exp, input dac_ctl_t act);
    if (exp !== act)
    begin
      fail_cnt = fail_cnt + 1;
      $display("[FAIL] t=%0t %s expected %h got %h", $time, name, exp, act);
      stop_with_failure();
    end
  endtask

  task automatic check_mux(input string name, input mux_sel_t exp, input mux_sel_t act);
    if (exp !== act)
    begin
      fail_cnt = fail_cnt + 1;
      $display("[FAIL] t=%0t %s expected %h got %h", $time, name, exp, act);
      stop_with_failure();
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (exp != act)
    begin
      fail_cnt = fail_cnt + 1;
      $display("[FAIL] t=%0t %s expected %0d got %0d", $time, name, exp, act);
      stop_with_failure();
    end
  endtask

  // frame rules applied to the shadow model
  function automatic void apply_ref_rules(input logic [16:0] bits, input int nbits,
                                          input logic special);
    reg_addr_t addr;
    reg_val_t  val;
    addr = bits[15:8];
    val  = bits[7:0];
    // special frames vanish without a trace
    if (!special)
    begin
      if (nbits != `SPI_FRAME_BITS)
        exp_frame_errs = exp_frame_errs + 1;
      else if (int'(addr) == `SPI_ADDR_MUX)
        exp_mux = val;
      else if (int'(addr) == `SPI_ADDR_LED)
        exp_led = val;
      else if (int'(addr) == `SPI_ADDR_DAC)
        exp_dac = val[3:0];
      else
        exp_addr_errs = exp_addr_errs + 1;
    end
  endfunction

  // compare process on the falling edge of cs
  always @(negedge cs)
  begin
    // routed selects mirror the mux while the host select is low
    if (cycle_cnt == mid_check_at)
      check_mux("periph_cs_n", ~exp_mux, periph_cs_n);
    if (cycle_cnt == end_check_at)
    begin
      check_led("led", exp_led, led);
      check_dac("dac_ctl", exp_dac, dac_ctl);
      check_mux("periph_cs_n", '1, periph_cs_n);
      check_count("frame_err pulses", exp_frame_errs, frame_err_seen);
      check_count("addr_err pulses", exp_addr_errs, addr_err_seen);
    end
  end

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge cs);
  endtask

  function automatic logic [31:0] next_rand();
    return $random(seed);
  endfunction

  // bit-banged frame sent msb first
  // DUT takes mosi on the sclk fall
  task automatic send_frame(input logic [16:0] bits, input int nbits, input logic special);
    int i;
    @(negedge cs);
    spi_ss_n    = 1'b0;
    spi_special = special;
    mid_check_at = cycle_cnt + 6;
    wait_cycles(SCLK_HALF);
    for (i = nbits - 1; i >= 0; i--)
    begin
      spi_mosi = bits[i];
      spi_sclk = 1'b1;
      wait_cycles(SCLK_HALF);
      spi_sclk = 1'b0;
      wait_cycles(SCLK_HALF);
    end
    spi_ss_n = 1'b1;
    apply_ref_rules(bits, nbits, special);
    // look 8 cycles after the frame closes
    end_check_at = cycle_cnt + 8;
    wait_cycles(SCLK_HALF);
    spi_special = 1'b0;
    wait_cycles(8);
  endtask

  task automatic write_reg(input reg_addr_t addr, input logic special);
    logic [31:0] rnd;
    rnd = next_rand();
    send_frame({1'b0, addr, rnd[7:0]}, `SPI_FRAME_BITS, special);
  endtask

  initial
  begin
    logic [31:0] rnd;
    reg_addr_t   addr;
    rst_n       = 1'b0;
    spi_sclk    = 1'b0;
    spi_ss_n    = 1'b1;
    spi_mosi    = 1'b0;
    spi_special = 1'b0;
    wait_cycles(16);
    rst_n = 1'b1;
    // reset values
    end_check_at = cycle_cnt + 2;
    wait_cycles(4);
    // good writes to every register
    repeat (12)
    begin
      write_reg(reg_addr_t'(`SPI_ADDR_LED), 1'b0);
      write_reg(reg_addr_t'(`SPI_ADDR_MUX), 1'b0);
      write_reg(reg_addr_t'(`SPI_ADDR_DAC), 1'b0);
    end
    // short and long frames
    repeat (2)
    begin
      rnd = next_rand();
      send_frame(rnd[16:0], 15, 1'b0);
      rnd = next_rand();
      send_frame(rnd[16:0], 17, 1'b0);
    end
    // special frames to real registers
    write_reg(reg_addr_t'(`SPI_ADDR_LED), 1'b1);
    write_reg(reg_addr_t'(`SPI_ADDR_MUX), 1'b1);
    write_reg(reg_addr_t'(`SPI_ADDR_DAC), 1'b1);
    // unknown addresses
    repeat (4)
    begin
      rnd  = next_rand();
      addr = rnd[15:8];
      if (int'(addr) == `SPI_ADDR_MUX || int'(addr) == `SPI_ADDR_LED ||
          int'(addr) == `SPI_ADDR_DAC)
        addr = addr ^ 8'h80;
      write_reg(addr, 1'b0);
    end
    // one more frame so the last mux value is seen on the selects
    write_reg(reg_addr_t'(`SPI_ADDR_LED), 1'b0);
    wait_cycles(4);
    if (fail_cnt == 0)
    begin
      $display("Simulation PASSED");
      $finish;
    end
    else
      stop_with_failure();
  end

endmodule
